// ==== lcd_display.f ====
logic/lcd_pkg.sv
logic/lcd_req_if.sv
logic/lcd_write_queue.sv
logic/lcd_controller.sv
logic/lcd_display.sv
sim/lcd_display_sva.sv
sim/lcd_display_tb.sv

// ==== Bender.yml ====
package:
  name: lcd_display

sources:
  - logic/lcd_pkg.sv
  - logic/lcd_req_if.sv
  - logic/lcd_write_queue.sv
  - logic/lcd_controller.sv
  - logic/lcd_display.sv
  - target: test
    files:
      - sim/lcd_display_sva.sv
      - sim/lcd_display_tb.sv

// ==== sim/lcd_display_patterns.txt ====
// one word per line: kind, gap (2 digits), rs, data
// kinds: 0 cfg, 1 write after gap plus jitter, 2 wait idle, 3 back-to-back write, 8 strobe, f end
00005a
200000
100148
103169
1960c0
200000
300141
300142
300143
300144
300145
300146
800038
80000e
800001
800006
800148
800169
8000c0
800141
800142
800143
800144
800145
f00000

// ==== sim/lcd_display_tb.sv ====
`timescale 1ns/100ps

module lcd_display_tb;
	import lcd_pkg::*;

	localparam int MAX_PAT    = 64;
	localparam int WAIT_LIMIT = PU_CYC + INIT_CYC + 20 * WRITE_CYC;

	logic              clk;
	logic              reset;
	logic [CFG_W-1:0]  cfg;
	logic              wr_valid;
	logic              wr_rs;
	logic [DATA_W-1:0] wr_data;
	logic              full;
	logic              lcd_e;
	logic              lcd_rs;
	logic [DATA_W-1:0] lcd_data;
	logic              busy;

	logic [23:0]       pat [0:MAX_PAT-1];   // {kind, gap, rs, data}
	logic              exp_rs [0:MAX_PAT-1];
	logic [DATA_W-1:0] exp_data [0:MAX_PAT-1];
	logic              got_rs [0:MAX_PAT-1];
	logic [DATA_W-1:0] got_data [0:MAX_PAT-1];
	int                n_exp;
	int                n_got;
	int                errors;
	int                timeouts;
	int                full_cycles;
	int                cyc;
	int                last_rise;
	int                e_width;
	logic              e_prev;
	logic              aborted;
	integer            seed;

	lcd_display DUT (
		.clk      (clk),
		.reset    (reset),
		.cfg      (cfg),
		.wr_valid (wr_valid),
		.wr_rs    (wr_rs),
		.wr_data  (wr_data),
		.full     (full),
		.lcd_e    (lcd_e),
		.lcd_rs   (lcd_rs),
		.lcd_data (lcd_data),
		.busy     (busy)
	);

	bind lcd_controller lcd_display_sva u_sva (
		.clk   (clk),
		.reset (reset),
		.state (state),
		.e     (e),
		.rs    (rs),
		.data  (data)
	);

	always #5 clk = ~clk;

	// strobe capture and pulse timing, sampled away from the active edge
	always @(negedge clk) begin
		if (reset) begin
			cyc     = 0;
			e_prev  = 1'b0;
			e_width = 0;
		end else begin
			cyc = cyc + 1;
			if (full)
				full_cycles++;
			if (lcd_e && !e_prev) begin
				if (n_got == 0) begin
					assert (cyc >= PU_CYC) else begin
						errors++;
						$display("Error at %0t: first strobe after only %0d cycles", $time, cyc);
					end
				end
				if (n_got >= 5) begin   // previous strobe was a write too
					assert (cyc - last_rise >= WRITE_CYC) else begin
						errors++;
						$display("Error at %0t: strobes %0d cycles apart", $time, cyc - last_rise);
					end
				end
				if (n_got < MAX_PAT) begin
					got_rs[n_got]   = lcd_rs;
					got_data[n_got] = lcd_data;
				end
				n_got++;
				last_rise = cyc;
				e_width   = 0;
			end
			if (lcd_e)
				e_width++;
			if (!lcd_e && e_prev && n_got > 4) begin   // end of a write pulse
				assert (e_width == E_HIGH_CYC) else begin
					errors++;
					$display("Error at %0t: write pulse of %0d cycles", $time, e_width);
				end
			end
			e_prev = lcd_e;
		end
	end

	task automatic host_write(input int gap, input logic rs, input logic [DATA_W-1:0] data);
		repeat (gap) begin
			@(posedge clk);
			wr_valid <= 1'b0;
		end
		@(posedge clk);
		wr_valid <= 1'b1;
		wr_rs    <= rs;
		wr_data  <= data;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(posedge clk);
		wr_valid <= 1'b0;
		@(negedge clk);
		while (busy !== 1'b0 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (busy !== 1'b0) begin
			timeouts++;
			aborted = 1'b1;
			$display("timed out after %0d cycles waiting for busy to fall", n);
		end
	endtask

	task automatic finish_run();
		int sva_fails;
		sva_fails = DUT.u_ctrl.u_sva.sva_errors;
		$display("errors: %0d, assertion failures: %0d, timeouts: %0d",
			errors, sva_fails, timeouts);
		if (errors == 0 && sva_fails == 0 && timeouts == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	initial begin
		logic [3:0] kind;
		int         g;
		bit         synced;
		bit         burst_seen;
		seed        = 51;
		errors      = 0;
		timeouts    = 0;
		full_cycles = 0;
		n_got       = 0;
		n_exp       = 0;
		aborted     = 1'b0;
		synced      = 1'b0;
		burst_seen  = 1'b0;
		clk         = 1'b0;
		reset       = 1'b1;
		cfg         = '0;
		wr_valid    = 1'b0;
		wr_rs       = 1'b0;
		wr_data     = '0;
		$readmemh("sim/lcd_display_patterns.txt", pat);
		for (int i = 0; i < MAX_PAT && pat[i][23:20] !== 4'hf; i++) begin
			if (pat[i][23:20] === 4'h0)
				cfg = pat[i][CFG_W-1:0];
			else if (pat[i][23:20] === 4'h8) begin
				exp_rs[n_exp]   = pat[i][8];
				exp_data[n_exp] = pat[i][7:0];
				n_exp++;
			end
		end
		assert (n_exp > 0) else begin
			errors++;
			$display("no expected strobes were read from the pattern file");
		end

		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (lcd_e === 1'b0 && busy === 1'b1) else begin
			errors++;
			$display("Error at %0t: lcd_e=%b busy=%b after reset", $time, lcd_e, busy);
		end

		for (int i = 0; i < MAX_PAT && !aborted && pat[i][23:20] !== 4'hf; i++) begin
			kind = pat[i][23:20];
			case (kind)
				4'h1: begin
					g = pat[i][19:12] + ($random(seed) & 7);   // jittered gap
					host_write(g, pat[i][8], pat[i][7:0]);
				end
				4'h2: begin
					wait_idle();
					if (!synced && !aborted) begin   // only the init sequence so far
						assert (n_got == 4) else begin
							errors++;
							$display("Error at %0t: %0d strobes before idle, 4 expected", $time, n_got);
						end
						synced = 1'b1;
					end
				end
				4'h3: begin
					if (!burst_seen) begin
						assert (full_cycles == 0) else begin
							errors++;
							$display("Error at %0t: full rose before the burst", $time);
						end
						burst_seen = 1'b1;
					end
					host_write(pat[i][19:12], pat[i][8], pat[i][7:0]);
				end
				default: ;
			endcase
		end

		if (!aborted)
			wait_idle();
		if (!aborted) begin
			assert (n_got == n_exp) else begin
				errors++;
				$display("Error at %0t: %0d strobes seen, %0d expected", $time, n_got, n_exp);
			end
			for (int k = 0; k < n_exp && k < n_got; k++) begin
				assert (got_rs[k] === exp_rs[k] && got_data[k] === exp_data[k]) else begin
					errors++;
					$display("Error at %0t: strobe %0d rs=%b data=%h, expected rs=%b data=%h",
						$time, k, got_rs[k], got_data[k], exp_rs[k], exp_data[k]);
				end
			end
			assert (full === 1'b0 && (!burst_seen || full_cycles > 0)) else begin
				errors++;
				$display("Error at %0t: full=%b, high for %0d cycles", $time, full, full_cycles);
			end
		end
		finish_run();
	end

endmodule

// ==== sim/lcd_display_sva.sv ====
`timescale 1ns/100ps

module lcd_display_sva (
	input logic                       clk,
	input logic                       reset,
	input logic [1:0]                 state,
	input logic                       e,
	input logic                       rs,
	input logic [lcd_pkg::DATA_W-1:0] data
);
	import lcd_pkg::*;

	// longest enable pulse, init window or write pulse
	localparam int E_MAX_CYC = (E_HIGH_CYC > INSTR_CYC) ? E_HIGH_CYC : INSTR_CYC;

	int sva_errors = 0;   // read back by the testbench

	e_width_limit: assert property (@(posedge clk) disable iff (reset)
		$rose(e) |-> ##[1:E_MAX_CYC] !e)
	else begin
		sva_errors++;
		$error("lcd_e stayed high longer than %0d cycles", E_MAX_CYC);
	end

	bus_stable_e_high: assert property (@(posedge clk) disable iff (reset)
		(e && $past(e)) |-> ($stable(data) && $stable(rs)))
	else begin
		sva_errors++;
		$error("lcd_data or lcd_rs changed while lcd_e was high");
	end

	e_low_powerup: assert property (@(posedge clk) disable iff (reset)
		(state == ST_POWERUP) |-> !e)
	else begin
		sva_errors++;
		$error("lcd_e went high during the power-up wait");
	end

endmodule

// ==== logic/lcd_display.sv ====
`timescale 1ns/100ps

module lcd_display (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [lcd_pkg::CFG_W-1:0]   cfg,
	input  logic                        wr_valid,
	input  logic                        wr_rs,
	input  logic [lcd_pkg::DATA_W-1:0]  wr_data,
	output logic                        full,
	output logic                        lcd_e,
	output logic                        lcd_rs,
	output logic [lcd_pkg::DATA_W-1:0]  lcd_data,
	output logic                        busy
);

	logic pending;

	lcd_req_if req_bus ();

	lcd_write_queue u_queue (
		.clk      (clk),
		.reset    (reset),
		.wr_valid (wr_valid),
		.wr_rs    (wr_rs),
		.wr_data  (wr_data),
		.full     (full),
		.pending  (pending),
		.req      (req_bus.source)
	);

	lcd_controller u_ctrl (
		.clk   (clk),
		.reset (reset),
		.cfg   (cfg),
		.req   (req_bus.sink),
		.e     (lcd_e),
		.rs    (lcd_rs),
		.data  (lcd_data)
	);

	// busy until the controller is idle and nothing waits in the queue
	assign busy = pending | req_bus.busy;

endmodule

// ==== logic/lcd_controller.sv ====
`timescale 1ns/100ps

module lcd_controller (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [lcd_pkg::CFG_W-1:0]   cfg,
	lcd_req_if.sink                     req,
	output logic                        e,
	output logic                        rs,
	output logic [lcd_pkg::DATA_W-1:0]  data
);
	import lcd_pkg::*;

	logic [1:0]        state;
	logic [CNT_W-1:0]  cnt;
	logic [CNT_W-1:0]  cnt_inc;
	logic [DATA_W-1:0] func_set;
	logic [DATA_W-1:0] disp_ctrl;
	logic [DATA_W-1:0] entry_mode;

	assign cnt_inc = cnt + 1'b1;

	// instruction words built from the cfg fields
	assign func_set   = {4'b0011, cfg[6], cfg[5], 2'b00};     // 8-bit, lines, font
	assign disp_ctrl  = {5'b00001, cfg[4], cfg[3], cfg[2]};   // on, cursor, blink
	assign entry_mode = {6'b000001, cfg[1], cfg[0]};          // inc, shift

	// {e, data} shown at a given init count
	function automatic logic [DATA_W:0] init_step(input logic [CNT_W-1:0] c);
		logic [DATA_W:0] step;
		step = '0;   // gaps keep e and data low
		if (c < CNT_W'(INSTR_CYC))
			step = {1'b1, func_set};
		else if (c < CNT_W'(INIT_DC_AT))
			step = '0;
		else if (c < CNT_W'(INIT_DC_AT + INSTR_CYC))
			step = {1'b1, disp_ctrl};
		else if (c < CNT_W'(INIT_CLR_AT))
			step = '0;
		else if (c < CNT_W'(INIT_CLR_AT + INSTR_CYC))
			step = {1'b1, 8'b0000_0001};   // clear display
		else if (c < CNT_W'(INIT_EM_AT))
			step = '0;
		else if (c < CNT_W'(INIT_EM_AT + INSTR_CYC))
			step = {1'b1, entry_mode};
		return step;
	endfunction

	// enable level at a given cycle of the write window
	function automatic logic write_e(input logic [CNT_W-1:0] c);
		return (c >= CNT_W'(E_SETUP_CYC)) && (c < CNT_W'(E_SETUP_CYC + E_HIGH_CYC));
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= ST_POWERUP;
			cnt      <= '0;
			e        <= 1'b0;
			rs       <= 1'b0;
			data     <= '0;
			req.busy <= 1'b1;
		end else begin
			case (state)
				ST_POWERUP: begin
					if (cnt == CNT_W'(PU_CYC - 1)) begin
						state     <= ST_INIT;
						cnt       <= '0;
						{e, data} <= init_step('0);   // function set starts next cycle
					end else begin
						cnt <= cnt_inc;
					end
				end
				ST_INIT: begin
					if (cnt == CNT_W'(INIT_CYC - 1)) begin
						state    <= ST_IDLE;
						cnt      <= '0;
						e        <= 1'b0;
						data     <= '0;
						req.busy <= 1'b0;   // entry wait done
					end else begin
						cnt       <= cnt_inc;
						{e, data} <= init_step(cnt_inc);
					end
				end
				ST_IDLE: begin
					if (req.enable) begin
						state    <= ST_WRITE;
						cnt      <= '0;
						rs       <= req.rs;   // held for the whole window
						data     <= req.data;
						e        <= write_e('0);
						req.busy <= 1'b1;
					end
				end
				ST_WRITE: begin
					if (cnt == CNT_W'(WRITE_CYC - 1)) begin
						state    <= ST_IDLE;
						cnt      <= '0;
						e        <= 1'b0;
						rs       <= 1'b0;
						data     <= '0;
						req.busy <= 1'b0;
					end else begin
						cnt <= cnt_inc;
						e   <= write_e(cnt_inc);
					end
				end
				default: state <= ST_POWERUP;
			endcase
		end
	end

endmodule

// ==== logic/lcd_write_queue.sv ====
`timescale 1ns/100ps

module lcd_write_queue (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        wr_valid,
	input  logic                        wr_rs,
	input  logic [lcd_pkg::DATA_W-1:0]  wr_data,
	output logic                        full,
	output logic                        pending,
	lcd_req_if.source                   req
);
	import lcd_pkg::*;

	logic              rs_mem [QUEUE_DEPTH];
	logic [DATA_W-1:0] data_mem [QUEUE_DEPTH];
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QCNT_W-1:0] count;
	logic [1:0]        issue_state;
	logic              push;
	logic              pop;

	function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] p);
		if (p == QPTR_W'(QUEUE_DEPTH - 1))
			return '0;   // wrap, depth need not be a power of two
		return p + 1'b1;
	endfunction

	assign full = (count == QCNT_W'(QUEUE_DEPTH));
	assign push = wr_valid && !full;   // writes while full are dropped
	assign pop  = (issue_state == IS_READY) && (count != '0) && !req.busy;

	// an entry in flight to the controller still counts as pending
	assign pending = (count != '0) || (issue_state != IS_READY);

	always_ff @(posedge clk) begin
		if (push) begin
			rs_mem[wr_ptr]   <= wr_rs;
			data_mem[wr_ptr] <= wr_data;
		end
		if (pop) begin
			req.rs   <= rs_mem[rd_ptr];   // valid with the enable pulse
			req.data <= data_mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			issue_state <= IS_READY;
			req.enable  <= 1'b0;
		end else begin
			req.enable <= pop;
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;   // both or neither, no change
			endcase

			case (issue_state)
				IS_READY: begin
					if (pop)
						issue_state <= IS_WAIT_HI;
				end
				IS_WAIT_HI: begin
					if (req.busy)
						issue_state <= IS_WAIT_LO;   // controller took it
				end
				IS_WAIT_LO: begin
					if (!req.busy)
						issue_state <= IS_READY;
				end
				default: issue_state <= IS_READY;
			endcase
		end
	end

endmodule

// ==== logic/lcd_req_if.sv ====
`timescale 1ns/100ps

interface lcd_req_if;
	import lcd_pkg::*;

	logic              enable;   // one-cycle request pulse
	logic              rs;       // 0 instruction, 1 character
	logic [DATA_W-1:0] data;
	logic              busy;     // controller occupied

	modport source (
		output enable,
		output rs,
		output data,
		input  busy
	);

	modport sink (
		input  enable,
		input  rs,
		input  data,
		output busy
	);

endinterface

// ==== logic/lcd_pkg.sv ====
package lcd_pkg;

	localparam int CLK_PER_UNIT     = 2;     // clocks per microsecond unit
	localparam int POWERUP_UNITS    = 500;
	localparam int INSTR_UNITS      = 10;
	localparam int GAP_UNITS        = 50;
	localparam int CLEAR_WAIT_UNITS = 200;
	localparam int ENTRY_WAIT_UNITS = 100;
	localparam int E_SETUP_UNITS    = 1;
	localparam int E_HIGH_UNITS     = 13;
	localparam int WRITE_UNITS      = 50;

	localparam int CNT_W       = 11;         // holds the power-up count
	localparam int DATA_W      = 8;
	localparam int CFG_W       = 7;          // {lines, font, on, cursor, blink, inc, shift}
	localparam int QUEUE_DEPTH = 4;

	localparam int QPTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

	// durations in clock cycles
	localparam int PU_CYC      = POWERUP_UNITS * CLK_PER_UNIT;
	localparam int INSTR_CYC   = INSTR_UNITS * CLK_PER_UNIT;
	localparam int GAP_CYC     = GAP_UNITS * CLK_PER_UNIT;
	localparam int CLEAR_CYC   = CLEAR_WAIT_UNITS * CLK_PER_UNIT;
	localparam int ENTRY_CYC   = ENTRY_WAIT_UNITS * CLK_PER_UNIT;
	localparam int E_SETUP_CYC = E_SETUP_UNITS * CLK_PER_UNIT;
	localparam int E_HIGH_CYC  = E_HIGH_UNITS * CLK_PER_UNIT;
	localparam int WRITE_CYC   = WRITE_UNITS * CLK_PER_UNIT;

	// init sequence start points, counted from the first function set cycle
	localparam int INIT_DC_AT  = INSTR_CYC + GAP_CYC;
	localparam int INIT_CLR_AT = INIT_DC_AT + INSTR_CYC + GAP_CYC;
	localparam int INIT_EM_AT  = INIT_CLR_AT + INSTR_CYC + CLEAR_CYC;
	localparam int INIT_CYC    = INIT_EM_AT + INSTR_CYC + ENTRY_CYC;

	localparam logic [1:0] ST_POWERUP = 2'd0;
	localparam logic [1:0] ST_INIT    = 2'd1;
	localparam logic [1:0] ST_IDLE    = 2'd2;
	localparam logic [1:0] ST_WRITE   = 2'd3;

	localparam logic [1:0] IS_READY   = 2'd0;
	localparam logic [1:0] IS_WAIT_HI = 2'd1;
	localparam logic [1:0] IS_WAIT_LO = 2'd2;

endpackage
